// File: sources.f
hdl/rv_exec_pkg.sv
hdl/instr_queue.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/shift_counter.sv
hdl/exec_fsm.sv
hdl/rv_exec_top.sv
test/tb_rv_exec.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - hdl/rv_exec_pkg.sv
  - hdl/instr_queue.sv
  - hdl/decoder.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/shift_counter.sv
  - hdl/exec_fsm.sv
  - hdl/rv_exec_top.sv
  - target: test
    files:
      - test/tb_rv_exec.sv

// File: test/tb_rv_exec.sv
module tb_rv_exec;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    rv_exec_pkg::instr_t    in_instr;
    logic                   credit_return;
    logic                   result_valid;
    rv_exec_pkg::result_t   result;

    logic   [31:0]          stim_q [$];                 // Stimulus table
    rv_exec_pkg::result_t   expect_q [$];               // Expected result per word
    logic   [31:0]          model_regs [32];            // Reference register file
    int                     credits;
    int                     errors;

    rv_exec_top #(.instr_depth(4)) DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    //////////////////////////////////////////////////
    // RV32I reference model

    function automatic rv_exec_pkg::result_t model_exec(input logic [31:0] w);
        rv_exec_pkg::result_t r;
        logic   [31:0] a;
        logic   [31:0] b;
        a = model_regs[w[19:15]];
        b = (w[6:0] == 7'b0110011) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        r = '{rd: w[11:7], value: '0, illegal: 1'b0};
        if (w[6:0] == 7'b0110111) begin
            r.value = {w[31:12], 12'h000};
        end else if (w[6:0] inside {7'b0010011, 7'b0110011}) begin
            case (w[14:12])
                3'b000:  r.value = (w[30] && w[5]) ? a - b : a + b;    // sub only on R type
                3'b001:  r.value = a << b[4:0];
                3'b010:  r.value = {31'd0, $signed(a) < $signed(b)};
                3'b011:  r.value = {31'd0, a < b};
                3'b100:  r.value = a ^ b;
                3'b101: begin
                    if (w[30]) r.value = $signed(a) >>> b[4:0];
                    else       r.value = a >> b[4:0];
                end
                3'b110:  r.value = a | b;
                default: r.value = a & b;
            endcase
        end else begin
            r.rd      = '0;
            r.illegal = 1'b1;
        end
        if (r.rd == 5'd0) r.value = '0;                 // x0 stays zero
        return r;
    endfunction

    task automatic add_test(input logic [31:0] w);
        rv_exec_pkg::result_t r;
        r = model_exec(w);
        if (!r.illegal && r.rd != 5'd0) model_regs[r.rd] = r.value;
        stim_q.push_back(w);
        expect_q.push_back(r);
    endtask

    task automatic check_result(input int idx, input rv_exec_pkg::result_t got,
            input rv_exec_pkg::result_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: result[%0d] got %0d/%h/%b expected %0d/%h/%b",
                     $time, idx, got.rd, got.value, got.illegal,
                     exp.rd, exp.value, exp.illegal);
            errors++;
        end else begin
            $display("test %0d ok: x%0d = %h illegal %b", idx, got.rd, got.value, got.illegal);
        end
    endtask

    task automatic check_credits(input int got);
        if (got != 4) begin
            $display("MISMATCH at %0t: credits got %0d expected %0d", $time, got, 4);
            errors++;
        end else begin
            $display("credits ok: %0d", got);
        end
    endtask

    task automatic build_table();
        logic   [31:0] rnd;
        logic   [4:0]  amt;
        foreach (model_regs[i]) model_regs[i] = '0;
        for (int k = 1; k <= 2; k++) begin              // First four go out as a burst
            rnd = $urandom();
            add_test({rnd[31:12], 5'(k), 7'b0110111});
            add_test(i_word(rnd[11:0], 5'(k), 3'b000, 5'(k)));
        end
        add_test({20'h80001, 5'd3, 7'b0110111});        // Negative base for imm ops
        add_test(i_word(12'hffb, 5'd3, 3'b000, 5'd4));
        add_test(i_word(12'hfff, 5'd3, 3'b100, 5'd5));
        add_test(i_word(12'h7f0, 5'd3, 3'b110, 5'd6));
        add_test(i_word(12'hff0, 5'd3, 3'b111, 5'd7));
        add_test(i_word(12'hfff, 5'd3, 3'b010, 5'd8));
        add_test(i_word(12'hfff, 5'd3, 3'b011, 5'd9));
        add_test(i_word(12'h005, 5'd3, 3'b011, 5'd10));
        for (int f = 0; f < 8; f++) begin
            if (f != 1 && f != 5) add_test(r_word(7'h00, 5'd2, 5'd1, 3'(f), 5'(11 + f)));
        end
        add_test(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd19));
        for (int k = 0; k < 3; k++) begin
            amt = (k == 2) ? 5'd31 : 5'(k);
            add_test(i_word({7'h00, amt}, 5'd3, 3'b001, 5'd20));
            add_test(i_word({7'h00, amt}, 5'd3, 3'b101, 5'd21));
            add_test(i_word({7'h20, amt}, 5'd3, 3'b101, 5'd22));
        end
        add_test(i_word(12'd13, 5'd0, 3'b000, 5'd23));
        add_test(r_word(7'h00, 5'd23, 5'd3, 3'b001, 5'd24));
        add_test(r_word(7'h00, 5'd23, 5'd3, 3'b101, 5'd25));
        add_test(r_word(7'h20, 5'd23, 5'd3, 3'b101, 5'd26));
        add_test(r_word(7'h20, 5'd2, 5'd3, 3'b101, 5'd27));
        add_test(i_word(12'h123, 5'd1, 3'b000, 5'd0));  // x0 target
        add_test(r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd28));
        add_test(i_word(12'hfff, 5'd0, 3'b000, 5'd29));
        add_test({7'd0, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011});   // sw, not supported
        add_test(r_word(7'h00, 5'd1, 5'd4, 3'b000, 5'd30));
    endtask

    //////////////////////////////////////////////////
    // Credit-tracking sender and result collector

    task automatic run_table(output int seen, output int idle);
        int sent;
        int gap;
        sent = 0;
        gap  = 0;
        seen = 0;
        idle = 0;
        while (seen < stim_q.size() && idle < 200) begin
            @(negedge clk);
            if (result_valid) begin
                check_result(seen, result, expect_q[seen]);
                seen++;
                idle = 0;
            end else begin
                idle++;
            end
            in_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (sent < stim_q.size() && credits > 0) begin
                in_valid = 1'b1;
                in_instr = stim_q[sent];
                credits--;
                sent++;
                gap = (sent < 4) ? 0 : $urandom_range(3);
            end
            if (credit_return) credits++;                   // Usable from the next cycle
        end
    endtask

    initial begin
        int seen;
        int idle;
        void'($urandom(32'h6fe9));
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        credits  = 4;
        errors   = 0;
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        run_table(seen, idle);
        if (idle >= 200) begin
            $display("Timeout: no result for test %0d within 200 cycles", seen);
            errors++;
        end
        check_credits(credits);
        $display("%0d tests, %0d results, %0d errors", stim_q.size(), seen, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/rv_exec_top.sv
module rv_exec_top #(
    parameter int instr_depth = 4
) (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   in_valid,
    input   rv_exec_pkg::instr_t    in_instr,
    output  logic                   credit_return,
    output  logic                   result_valid,
    output  rv_exec_pkg::result_t   result
);

    rv_exec_pkg::instr_t            head;
    rv_exec_pkg::decoded_t          dec;
    logic   [rv_exec_pkg::xlen-1:0] rs1_value;
    logic   [rv_exec_pkg::xlen-1:0] rs2_value;
    logic   [rv_exec_pkg::xlen-1:0] alu_value;
    logic   [rv_exec_pkg::xlen-1:0] result_value;
    logic   [4:0]                   shift_amount;
    logic                           empty;
    logic                           pop;
    logic                           issue;
    logic                           shift_step;
    logic                           count_load;
    logic                           count_step;
    logic                           count_done;
    logic                           write;

    assign shift_amount = dec.use_imm ? dec.imm[4:0] : rs2_value[4:0];
    assign result_value = (dec.rd == '0) ? '0 : alu_value;     // x0 reads as zero
    assign result       = '{rd: dec.rd, value: result_value, illegal: dec.illegal};

    instr_queue #(.instr_depth(instr_depth)) u_queue (
        .clk, .reset, .in_valid, .in_instr, .pop, .head, .empty, .credit_return
    );

    decoder u_decoder (.instr(head), .dec);

    reg_file u_reg_file (
        .clk, .reset, .rs1(dec.rs1), .rs2(dec.rs2), .rs1_value, .rs2_value,
        .write, .rd(dec.rd), .rd_value(alu_value)
    );

    alu u_alu (
        .clk, .reset, .dec, .rs1_value, .rs2_value, .issue, .shift_step, .value(alu_value)
    );

    shift_counter u_shift_counter (
        .clk, .reset, .load(count_load), .amount(shift_amount), .step(count_step),
        .done(count_done)
    );

    exec_fsm u_fsm (
        .clk, .reset, .empty, .dec, .pop, .issue, .shift_step, .count_load, .count_step,
        .count_done, .write, .result_valid
    );

endmodule

// File: hdl/exec_fsm.sv
module exec_fsm (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   empty,
    input   rv_exec_pkg::decoded_t  dec,
    output  logic                   pop,
    output  logic                   issue,
    output  logic                   shift_step,
    output  logic                   count_load,
    output  logic                   count_step,
    input   logic                   count_done,
    output  logic                   write,
    output  logic                   result_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_shift,
        st_retire
    } state_t;

    state_t state;
    state_t state_next;
    logic   retire;

    always_ff @(posedge clk) begin
        if (reset) state <= st_idle;
        else       state <= state_next;
    end

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        issue      = 1'b0;
        shift_step = 1'b0;
        count_load = 1'b0;
        count_step = 1'b0;
        retire     = 1'b0;
        case (state)
            st_idle: begin
                if (!empty) begin
                    pop        = 1'b1;              // Head register takes the word
                    state_next = st_issue;
                end
            end
            st_issue: begin
                issue      = 1'b1;
                count_load = dec.is_shift;
                state_next = dec.is_shift ? st_shift : st_retire;
            end
            st_shift: begin
                if (count_done) begin
                    retire     = 1'b1;              // Last step landed last cycle
                    state_next = st_idle;
                end else begin
                    shift_step = 1'b1;
                    count_step = 1'b1;
                end
            end
            default: begin
                retire     = 1'b1;
                state_next = st_idle;
            end
        endcase
    end

    assign write        = retire && !dec.illegal;
    assign result_valid = retire;

endmodule

// File: hdl/shift_counter.sv
module shift_counter (
    input   logic           clk,
    input   logic           reset,
    input   logic           load,
    input   logic   [4:0]   amount,
    input   logic           step,
    output  logic           done
);

    logic   [4:0]   remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= amount;
        end else if (step) begin
            remaining <= remaining - 5'd1;
        end
    end

    assign done = (remaining == '0);

    // An extra step would wrap the count and over-shift the ALU
    a_no_step_when_done: assert property (@(posedge clk) disable iff (reset)
        step |-> !done);

endmodule

// File: hdl/alu.sv
module alu (
    input   logic                           clk,
    input   logic                           reset,
    input   rv_exec_pkg::decoded_t          dec,
    input   logic   [rv_exec_pkg::xlen-1:0] rs1_value,
    input   logic   [rv_exec_pkg::xlen-1:0] rs2_value,
    input   logic                           issue,
    input   logic                           shift_step,
    output  logic   [rv_exec_pkg::xlen-1:0] value
);

    logic   [rv_exec_pkg::xlen-1:0] operand_b;
    logic   [rv_exec_pkg::xlen-1:0] issue_value;

    always_comb begin
        operand_b = dec.use_imm ? dec.imm : rs2_value;
        case (dec.alu_op)
            rv_exec_pkg::alu_op_add:  issue_value = rs1_value + operand_b;
            rv_exec_pkg::alu_op_sub:  issue_value = rs1_value - operand_b;
            rv_exec_pkg::alu_op_xor:  issue_value = rs1_value ^ operand_b;
            rv_exec_pkg::alu_op_or:   issue_value = rs1_value | operand_b;
            rv_exec_pkg::alu_op_and:  issue_value = rs1_value & operand_b;
            rv_exec_pkg::alu_op_slt:  issue_value = {31'd0, $signed(rs1_value) < $signed(operand_b)};
            rv_exec_pkg::alu_op_sltu: issue_value = {31'd0, rs1_value < operand_b};
            rv_exec_pkg::alu_op_pass_imm: issue_value = dec.imm;
            default:                  issue_value = rs1_value;   // Shift start value
        endcase
    end

    //////////////////////////////////////////////////
    // Result register, doubles as serial shifter

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
        end else if (issue) begin
            value <= issue_value;
        end else if (shift_step) begin
            case (dec.alu_op)
                rv_exec_pkg::alu_op_sll: value <= {value[30:0], 1'b0};
                rv_exec_pkg::alu_op_sra: value <= {value[31], value[31:1]};  // Sign fill
                default:                 value <= {1'b0, value[31:1]};
            endcase
        end
    end

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input   logic                           clk,
    input   logic                           reset,
    input   rv_exec_pkg::reg_addr_t         rs1,
    input   rv_exec_pkg::reg_addr_t         rs2,
    output  logic   [rv_exec_pkg::xlen-1:0] rs1_value,
    output  logic   [rv_exec_pkg::xlen-1:0] rs2_value,
    input   logic                           write,
    input   rv_exec_pkg::reg_addr_t         rd,
    input   logic   [rv_exec_pkg::xlen-1:0] rd_value
);

    logic   [rv_exec_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != '0) begin   // x0 writes dropped
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/decoder.sv
module decoder (
    input   rv_exec_pkg::instr_t    instr,
    output  rv_exec_pkg::decoded_t  dec
);

    logic   [rv_exec_pkg::xlen-1:0] i_imm;
    logic   [rv_exec_pkg::xlen-1:0] u_imm;

    // funct3 to ALU op, alt is instruction bit 30
    function automatic rv_exec_pkg::alu_op_t arith_op(
        input rv_exec_pkg::arith_f3_t f3,
        input logic                   alt,
        input logic                   is_reg
    );
        case (f3)
            rv_exec_pkg::arith_f3_add:
                return (alt && is_reg) ? rv_exec_pkg::alu_op_sub : rv_exec_pkg::alu_op_add;
            rv_exec_pkg::arith_f3_sll:  return rv_exec_pkg::alu_op_sll;
            rv_exec_pkg::arith_f3_slt:  return rv_exec_pkg::alu_op_slt;
            rv_exec_pkg::arith_f3_sltu: return rv_exec_pkg::alu_op_sltu;
            rv_exec_pkg::arith_f3_xor:  return rv_exec_pkg::alu_op_xor;
            rv_exec_pkg::arith_f3_sr:
                return alt ? rv_exec_pkg::alu_op_sra : rv_exec_pkg::alu_op_srl;
            rv_exec_pkg::arith_f3_or:   return rv_exec_pkg::alu_op_or;
            default:                    return rv_exec_pkg::alu_op_and;
        endcase
    endfunction

    always_comb begin
        i_imm = {{20{instr.i_view.imm_11_0[11]}}, instr.i_view.imm_11_0};
        u_imm = {instr.i_view.imm_11_0, instr.i_view.rs1, instr.i_view.funct3, 12'h000};

        dec          = '0;
        dec.rd       = instr.r_view.rd;
        dec.is_shift = instr.r_view.funct3 inside {rv_exec_pkg::arith_f3_sll,
                                                   rv_exec_pkg::arith_f3_sr};

        case (instr.r_view.opcode)
            rv_exec_pkg::op_lui: begin
                dec.alu_op   = rv_exec_pkg::alu_op_pass_imm;
                dec.use_imm  = 1'b1;
                dec.imm      = u_imm;
                dec.is_shift = 1'b0;
            end
            rv_exec_pkg::op_imm: begin
                dec.rs1      = instr.i_view.rs1;
                dec.use_imm  = 1'b1;
                dec.imm      = i_imm;                // srai keeps bit 10, shamt is imm[4:0]
                dec.alu_op   = arith_op(instr.i_view.funct3, instr.i_view.imm_11_0[10], 1'b0);
            end
            rv_exec_pkg::op_reg: begin
                dec.rs1      = instr.r_view.rs1;
                dec.rs2      = instr.r_view.rs2;
                dec.alu_op   = arith_op(instr.r_view.funct3, instr.r_view.funct7[5], 1'b1);
            end
            default: begin
                // Unsupported opcode, retires with nothing written
                dec.illegal  = 1'b1;
                dec.rd       = '0;
                dec.alu_op   = rv_exec_pkg::alu_op_pass_imm;
                dec.use_imm  = 1'b1;
                dec.is_shift = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/instr_queue.sv
module instr_queue #(
    parameter int instr_depth = 4
) (
    input   logic                   clk,
    input   logic                   reset,
    input   logic                   in_valid,
    input   rv_exec_pkg::instr_t    in_instr,
    input   logic                   pop,
    output  rv_exec_pkg::instr_t    head,
    output  logic                   empty,
    output  logic                   credit_return
);

    localparam int ptr_w = $clog2(instr_depth);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(instr_depth - 1);
    localparam logic [ptr_w:0]   full_count = (ptr_w + 1)'(instr_depth);

    rv_exec_pkg::instr_t    mem [instr_depth];
    logic   [ptr_w-1:0]     wr_ptr;
    logic   [ptr_w-1:0]     rd_ptr;
    logic   [ptr_w:0]       count;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == last_ptr) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_ptr] <= in_instr;
        if (pop) head <= mem[rd_ptr];                // Held for the whole execution
    end

    assign empty         = (count == '0);
    assign credit_return = pop;                     // Slot is free once popped

    // Sender spent a credit it did not have
    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> count != full_count);

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

// File: hdl/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [6:0] {
        op_lui          = 7'b0110111,   // U load upper immediate
        op_imm          = 7'b0010011,   // I arith with immediate operand
        op_reg          = 7'b0110011    // R arith with register operands
    } rv_op_t;

    typedef enum logic [2:0] {
        arith_f3_add    = 3'b000,       // Bit 30 picks sub on op_reg
        arith_f3_sll    = 3'b001,
        arith_f3_slt    = 3'b010,
        arith_f3_sltu   = 3'b011,
        arith_f3_xor    = 3'b100,
        arith_f3_sr     = 3'b101,       // Bit 30 picks arithmetic
        arith_f3_or     = 3'b110,
        arith_f3_and    = 3'b111
    } arith_f3_t;

    typedef enum logic [3:0] {
        alu_op_add      = 4'd0,
        alu_op_sub      = 4'd1,
        alu_op_xor      = 4'd2,
        alu_op_or       = 4'd3,
        alu_op_and      = 4'd4,
        alu_op_slt      = 4'd5,
        alu_op_sltu     = 4'd6,
        alu_op_sll      = 4'd7,
        alu_op_srl      = 4'd8,
        alu_op_sra      = 4'd9,
        alu_op_pass_imm = 4'd10         // lui
    } alu_op_t;

    // Same 32-bit word, seen as R type or as I type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            arith_f3_t  funct3;
            reg_addr_t  rd;
            rv_op_t     opcode;
        } r_view;
        struct packed {
            logic [11:0] imm_11_0;
            reg_addr_t   rs1;
            arith_f3_t   funct3;
            reg_addr_t   rd;
            rv_op_t      opcode;
        } i_view;
    } instr_t;

    typedef struct packed {
        reg_addr_t          rs1;
        reg_addr_t          rs2;
        reg_addr_t          rd;
        alu_op_t            alu_op;
        logic               use_imm;    // Operand b from imm
        logic [xlen-1:0]    imm;
        logic               is_shift;
        logic               illegal;
    } decoded_t;

    typedef struct packed {
        reg_addr_t          rd;
        logic [xlen-1:0]    value;
        logic               illegal;
    } result_t;

endpackage : rv_exec_pkg
